//--- rtl/audio_pkg.sv
// audio mixer widths and sample types and fetch state encoding and default parameters
package audio_pkg;

    parameter int NCHAN_DEFAULT = 4;            // channels played by default
    parameter int DAC_W_DEFAULT = 8;            // pdm dac resolution in bits
    parameter int MIX_SHIFT     = 6;            // mix sum divided by 64

    typedef logic signed [7:0]  sample_t;       // one signed 8 bit sample
    typedef logic [6:0]         vol_t;          // unsigned channel volume
    typedef logic [14:0]        period_t;       // period reload value
    typedef logic [15:0]        addr_t;         // sample memory word address
    typedef logic [15:0]        word_t;         // two samples with first in high byte
    typedef logic signed [17:0] mix_acc_t;      // holds four full scale products

    // sample fetch FSM
    typedef enum logic [1:0] {
        FETCH_CHECK,                            // look at need_word of current channel
        FETCH_REQUEST,                          // raise req with pointer or start
        FETCH_WAIT_ACK,                         // hold req until memory acks
        FETCH_NEXT                              // step to next channel
    } fetch_state_e;

endpackage

//--- rtl/sample_load_if.sv
// sample word request and load interface between fetch engine and channel buffer
`timescale 1ns/1ps

interface sample_load_if #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT
);
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    logic [NCHAN-1:0]   need_word;              // one bit per channel with empty word
    logic               load_valid;             // one cycle load strobe
    logic [CHAN_W-1:0]  load_chan;              // channel being loaded
    audio_pkg::word_t   load_word;              // fetched sample word

    modport fetch_mp (
        input  need_word,
        output load_valid, load_chan, load_word
    );

    modport buffer_mp (
        output need_word,
        input  load_valid, load_chan, load_word
    );

endinterface

//--- rtl/pdm_dac.sv
// first order pulse density modulator for one audio output
`timescale 1ns/1ps

module pdm_dac #(
    parameter int DAC_W = audio_pkg::DAC_W_DEFAULT
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic [DAC_W-1:0]    value_i,
    output logic                pulse_o
);
    logic [DAC_W:0] acc_q;                      // sum with carry on top

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= {1'b0, acc_q[DAC_W-1:0]} + {1'b0, value_i};    // carry rate tracks value
        end
    end

    assign pulse_o = acc_q[DAC_W];              // value pulses per 2**DAC_W cycles

endmodule

//--- rtl/sample_fetch.sv
// sample fetch engine with per-channel pointer and length counters and memory request FSM
`timescale 1ns/1ps

module sample_fetch #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            enable_i,
    input  logic [NCHAN-1:0]                restart_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    start_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    length_i,
    input  logic                            mem_ack_i,
    input  audio_pkg::word_t                mem_word_i,
    output logic                            mem_req_o,
    output audio_pkg::addr_t                mem_addr_o,
    output logic [NCHAN-1:0]                reload_o,
    sample_load_if.fetch_mp                 load
);
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    audio_pkg::fetch_state_e    state;          // fetch FSM state
    logic [CHAN_W-1:0]          chan;           // channel being visited
    logic [NCHAN-1:0]           restart_pend;   // pointer invalid so next fetch uses start
    audio_pkg::addr_t           ptr [NCHAN];    // next word address per channel
    audio_pkg::addr_t           lencnt [NCHAN]; // words left before wrap
    logic [16:0]                len_dec;        // lencnt minus one with borrow on top
    logic                       wrap;           // request start this time
    logic                       do_req;         // request issued this cycle
    logic                       do_load;        // word arrives this cycle

    assign len_dec = {1'b0, lencnt[chan]} - 17'd1;
    assign wrap    = restart_pend[chan] || len_dec[16];     // borrow means length used up
    assign do_req  = enable_i && (state == audio_pkg::FETCH_REQUEST);
    assign do_load = enable_i && (state == audio_pkg::FETCH_WAIT_ACK) && mem_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state           <= audio_pkg::FETCH_CHECK;
            chan            <= '0;
            mem_req_o       <= 1'b0;
            reload_o        <= '0;
            load.load_valid <= 1'b0;
            restart_pend    <= '1;                  // all pointers invalid
        end else begin
            reload_o        <= '0;                  // strobes last one cycle
            load.load_valid <= 1'b0;
            case (state)
                audio_pkg::FETCH_CHECK: begin
                    if (load.need_word[chan]) begin
                        state <= audio_pkg::FETCH_REQUEST;
                    end else begin
                        state <= audio_pkg::FETCH_NEXT;     // word still full so skip
                    end
                end
                audio_pkg::FETCH_REQUEST: begin
                    mem_req_o <= 1'b1;                      // address set in payload block
                    if (wrap) begin
                        reload_o[chan]     <= 1'b1;         // rises with req for start
                        restart_pend[chan] <= 1'b0;
                    end
                    state <= audio_pkg::FETCH_WAIT_ACK;
                end
                audio_pkg::FETCH_WAIT_ACK: begin
                    if (mem_ack_i) begin
                        mem_req_o       <= 1'b0;            // drop req after ack
                        load.load_valid <= 1'b1;            // hand word to buffer
                        state           <= audio_pkg::FETCH_NEXT;
                    end
                end
                audio_pkg::FETCH_NEXT: begin
                    if (chan == CHAN_W'(NCHAN - 1)) begin
                        chan <= '0;
                    end else begin
                        chan <= chan + 1'b1;
                    end
                    state <= audio_pkg::FETCH_CHECK;
                end
                default: begin
                    state <= audio_pkg::FETCH_CHECK;
                end
            endcase

            for (int i = 0; i < NCHAN; i++) begin
                if (restart_i[i]) begin
                    restart_pend[i] <= 1'b1;        // wins over clear above
                end
            end

            if (!enable_i) begin                    // park on channel 0
                state           <= audio_pkg::FETCH_CHECK;
                chan            <= '0;
                mem_req_o       <= 1'b0;
                reload_o        <= '0;
                load.load_valid <= 1'b0;
                restart_pend    <= '1;
            end
        end
    end

    // pointers and load payload
    always_ff @(posedge clk) begin
        if (do_req) begin
            if (wrap) begin
                mem_addr_o   <= start_i[chan];
                ptr[chan]    <= start_i[chan] + 1'b1;
                lencnt[chan] <= length_i[chan];     // start plus length is last word
            end else begin
                mem_addr_o   <= ptr[chan];
                ptr[chan]    <= ptr[chan] + 1'b1;
                lencnt[chan] <= len_dec[15:0];
            end
        end
        if (do_load) begin
            load.load_chan <= chan;
            load.load_word <= mem_word_i;
        end
    end

endmodule

//--- rtl/channel_buffer.sv
// channel buffer with per-channel sample words and period counters and byte selection
`timescale 1ns/1ps

module channel_buffer #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT
) (
    input  logic                                clk,
    input  logic                                reset_i,
    input  logic                                enable_i,
    input  logic [NCHAN-1:0]                    restart_i,
    input  audio_pkg::period_t [NCHAN-1:0]      period_i,
    output audio_pkg::sample_t [NCHAN-1:0]      sample_vals_o,
    sample_load_if.buffer_mp                    load
);
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    audio_pkg::word_t   word_q [NCHAN];         // held sample word per channel
    logic [NCHAN-1:0]   word_ok;                // word holds unplayed bytes
    logic [NCHAN-1:0]   low_phase;              // next byte is the low one
    audio_pkg::period_t period_cnt [NCHAN];     // period down counter
    logic [NCHAN-1:0]   tick;                   // counter underflows this cycle

    assign load.need_word = ~word_ok;           // empty word asks for a fetch

    always_comb begin
        for (int i = 0; i < NCHAN; i++) begin
            tick[i] = (period_cnt[i] == '0);    // decrement past zero
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            word_ok       <= '0;
            low_phase     <= '0;
            sample_vals_o <= '0;
            for (int i = 0; i < NCHAN; i++) begin
                period_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCHAN; i++) begin
                if (tick[i]) begin
                    period_cnt[i] <= period_i[i];   // period plus one cycles per sample
                    if (word_ok[i]) begin
                        sample_vals_o[i] <= low_phase[i] ? word_q[i][7:0] : word_q[i][15:8];
                        low_phase[i]     <= ~low_phase[i];
                        if (low_phase[i]) begin
                            word_ok[i] <= 1'b0;     // both bytes played
                        end
                    end
                    // empty word keeps the last sample which is the low byte
                end else begin
                    period_cnt[i] <= period_cnt[i] - 1'b1;
                end

                if (load.load_valid && (load.load_chan == CHAN_W'(i))) begin
                    word_ok[i]   <= 1'b1;
                    low_phase[i] <= 1'b0;           // high byte plays first
                end

                if (!enable_i || restart_i[i]) begin
                    word_ok[i]    <= 1'b0;          // flush word
                    low_phase[i]  <= 1'b0;
                    period_cnt[i] <= period_i[i];
                end
                if (!enable_i) begin
                    sample_vals_o[i] <= '0;         // rest at mid scale
                end
            end
        end
    end

    // word storage
    always_ff @(posedge clk) begin
        if (load.load_valid) begin
            word_q[load.load_chan] <= load.load_word;
        end
    end

endmodule

//--- rtl/voice_mixer.sv
// voice mixer with frame sequencer and signed multiply accumulate and clamp and two pdm dacs
`timescale 1ns/1ps

module voice_mixer #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT,
    parameter int DAC_W = audio_pkg::DAC_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  audio_pkg::sample_t [NCHAN-1:0]  sample_vals_i,
    input  audio_pkg::vol_t [NCHAN-1:0]     vol_l_i,
    input  audio_pkg::vol_t [NCHAN-1:0]     vol_r_i,
    output logic                            pdm_l_o,
    output logic                            pdm_r_o
);
    localparam int CHAN_W = (NCHAN > 1) ? $clog2(NCHAN) : 1;

    logic [CHAN_W-1:0]      mix_chan;           // channel being accumulated
    logic                   mix_last;           // extra frame cycle to latch and clear
    audio_pkg::sample_t     cur_sample;         // sample of mix_chan
    logic signed [15:0]     prod_l;             // sample times left volume
    logic signed [15:0]     prod_r;             // sample times right volume
    audio_pkg::mix_acc_t    acc_l;              // left frame sum
    audio_pkg::mix_acc_t    acc_r;              // right frame sum
    logic [DAC_W-1:0]       dac_l;              // offset binary left level
    logic [DAC_W-1:0]       dac_r;              // offset binary right level

    // scale and clamp a frame sum then shift to offset binary
    function automatic logic [DAC_W-1:0] to_dac(input audio_pkg::mix_acc_t acc);
        audio_pkg::mix_acc_t lvl;
        lvl = acc >>> audio_pkg::MIX_SHIFT;     // floor divide by 64
        if (lvl < -18'sd128) begin
            lvl = -18'sd128;
        end else if (lvl > 18'sd127) begin
            lvl = 18'sd127;
        end
        return DAC_W'(lvl + 18'sd128);
    endfunction

    assign cur_sample = sample_vals_i[mix_chan];
    assign prod_l     = cur_sample * $signed({1'b0, vol_l_i[mix_chan]});   // volume kept positive
    assign prod_r     = cur_sample * $signed({1'b0, vol_r_i[mix_chan]});

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_chan <= '0;
            mix_last <= 1'b0;
            acc_l    <= '0;
            acc_r    <= '0;
            dac_l    <= DAC_W'(128);            // mid scale
            dac_r    <= DAC_W'(128);
        end else if (mix_last) begin
            dac_l    <= to_dac(acc_l);          // once per frame
            dac_r    <= to_dac(acc_r);
            acc_l    <= '0;
            acc_r    <= '0;
            mix_last <= 1'b0;
            mix_chan <= '0;
        end else begin
            acc_l <= acc_l + audio_pkg::mix_acc_t'(prod_l);
            acc_r <= acc_r + audio_pkg::mix_acc_t'(prod_r);
            if (mix_chan == CHAN_W'(NCHAN - 1)) begin
                mix_last <= 1'b1;               // frame is NCHAN plus 1 cycles
            end else begin
                mix_chan <= mix_chan + 1'b1;
            end
        end
    end

    pdm_dac #(
        .DAC_W      (DAC_W)
    ) u_dac_l (
        .clk        (clk),
        .reset_i    (reset_i),
        .value_i    (dac_l),
        .pulse_o    (pdm_l_o)
    );

    pdm_dac #(
        .DAC_W      (DAC_W)
    ) u_dac_r (
        .clk        (clk),
        .reset_i    (reset_i),
        .value_i    (dac_r),
        .pulse_o    (pdm_r_o)
    );

endmodule

//--- rtl/audio_mixer_top.sv
// audio sample player top level wiring fetch engine and channel buffer and voice mixer
`timescale 1ns/1ps

module audio_mixer_top #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT,
    parameter int DAC_W = audio_pkg::DAC_W_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset_i,
    // controls
    input  logic                            enable_i,
    input  logic [NCHAN-1:0]                restart_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    start_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    length_i,
    input  audio_pkg::period_t [NCHAN-1:0]  period_i,
    input  audio_pkg::vol_t [NCHAN-1:0]     vol_l_i,
    input  audio_pkg::vol_t [NCHAN-1:0]     vol_r_i,
    // sample memory
    output logic                            mem_req_o,
    output audio_pkg::addr_t                mem_addr_o,
    input  logic                            mem_ack_i,
    input  audio_pkg::word_t                mem_word_i,
    // outputs
    output logic [NCHAN-1:0]                reload_o,
    output logic                            pdm_l_o,
    output logic                            pdm_r_o
);
    audio_pkg::sample_t [NCHAN-1:0] sample_vals;    // current sample per channel

    sample_load_if #(.NCHAN(NCHAN)) load_if ();

    sample_fetch #(
        .NCHAN          (NCHAN)
    ) u_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .restart_i      (restart_i),
        .start_i        (start_i),
        .length_i       (length_i),
        .mem_ack_i      (mem_ack_i),
        .mem_word_i     (mem_word_i),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .reload_o       (reload_o),
        .load           (load_if.fetch_mp)
    );

    channel_buffer #(
        .NCHAN          (NCHAN)
    ) u_buffer (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (enable_i),
        .restart_i      (restart_i),
        .period_i       (period_i),
        .sample_vals_o  (sample_vals),
        .load           (load_if.buffer_mp)
    );

    voice_mixer #(
        .NCHAN          (NCHAN),
        .DAC_W          (DAC_W)
    ) u_mixer (
        .clk            (clk),
        .reset_i        (reset_i),
        .sample_vals_i  (sample_vals),
        .vol_l_i        (vol_l_i),
        .vol_r_i        (vol_r_i),
        .pdm_l_o        (pdm_l_o),
        .pdm_r_o        (pdm_r_o)
    );

endmodule

//--- tb/audio_mixer_asserts.sv
// concurrent assertions on the memory handshake and reload strobes of the fetch engine
`timescale 1ns/1ps

module audio_mixer_asserts #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT
) (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                enable_i,
    input  logic                req_i,
    input  audio_pkg::addr_t    addr_i,
    input  logic                ack_i,
    input  logic [NCHAN-1:0]    reload_i
);
    int err_cnt = 0;                            // failed assertions so far

    // req held with stable address until ack
    a_req_hold: assert property (@(posedge clk) disable iff (reset_i)
        (req_i && !ack_i && enable_i) |=> (req_i && $stable(addr_i)))
        else begin
            $error("request dropped or address moved before ack");
            err_cnt++;
        end

    a_reload_onehot: assert property (@(posedge clk) disable iff (reset_i)
        $onehot0(reload_i))
        else begin
            $error("reload strobe on more than one channel");
            err_cnt++;
        end

    a_no_req_disabled: assert property (@(posedge clk) disable iff (reset_i)
        !enable_i |=> !req_i)
        else begin
            $error("request while disabled");
            err_cnt++;
        end

    // reload only on the request rise
    a_reload_with_req: assert property (@(posedge clk) disable iff (reset_i)
        (reload_i != '0) |-> (req_i && !$past(req_i)))
        else begin
            $error("reload without a request rise");
            err_cnt++;
        end

endmodule

//--- tb/audio_checker.sv
// checker for address walk, reload strobes and pdm pulse counts with per-test result lines
`timescale 1ns/1ps

module audio_checker #(
    parameter int NCHAN = audio_pkg::NCHAN_DEFAULT
) (
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            enable_i,
    input  logic [NCHAN-1:0]                restart_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    start_i,
    input  audio_pkg::addr_t [NCHAN-1:0]    length_i,
    input  logic                            req_i,
    input  audio_pkg::addr_t                addr_i,
    input  logic [NCHAN-1:0]                reload_i,
    input  logic                            pdm_l_i,
    input  logic                            pdm_r_i,
    output int                              pass_cnt_o,
    output int                              fail_cnt_o,
    output int                              err_cnt_o
);
    string              cur_name = "startup";   // test running now
    int                 err_base = 0;           // error count when the test began
    logic [NCHAN-1:0]   pend;                   // next request must be start
    logic [NCHAN-1:0]   flush_d;                // restart or disable seen one cycle ago
    logic               req_d;
    audio_pkg::addr_t   exp_next [NCHAN];       // expected next pointer per channel

    initial begin
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        err_cnt_o  = 0;
    end

    function automatic int find_chan(input audio_pkg::addr_t a);
        for (int c = 0; c < NCHAN; c++) begin
            if ({1'b0, a} >= {1'b0, start_i[c]} &&
                {1'b0, a} <= {1'b0, start_i[c]} + {1'b0, length_i[c]}) begin
                return c;
            end
        end
        return -1;
    endfunction

    // sampled mid-cycle, flush applies one cycle late like the fetch engine
    always @(negedge clk) begin
        int c;
        audio_pkg::addr_t exp_a;
        logic [NCHAN-1:0] exp_rl;
        if (reset_i) begin
            pend    = '1;                       // pointers invalid after reset
            flush_d = '0;
            req_d   = 1'b0;
        end else begin
            if (req_i && !req_d) begin
                c = find_chan(addr_i);
                if (c < 0) begin
                    err_cnt_o++;
                    $display("test %s: request address %h lies outside every channel",
                             cur_name, addr_i);
                end else begin
                    exp_a  = pend[c] ? start_i[c] : exp_next[c];
                    exp_rl = (exp_a == start_i[c]) ? (NCHAN'(1) << c) : '0;
                    if (addr_i !== exp_a) begin
                        err_cnt_o++;
                        $display("** Error %s: address ch%0d expected %h actual %h",
                                 cur_name, c, exp_a, addr_i);
                    end
                    if (reload_i !== exp_rl) begin
                        err_cnt_o++;
                        $display("** Error %s: reload expected %b actual %b",
                                 cur_name, exp_rl, reload_i);
                    end
                    pend[c]     = 1'b0;
                    exp_next[c] = (addr_i == start_i[c] + length_i[c]) ? start_i[c]
                                                                       : addr_i + 1'b1;
                end
            end else if (reload_i != '0) begin
                err_cnt_o++;
                $display("test %s: reload strobe %b without a request rise",
                         cur_name, reload_i);
            end
            pend    = pend | flush_d;
            flush_d = restart_i | {NCHAN{!enable_i}};
            req_d   = req_i;
        end
    end

    task automatic begin_test(input string nm);
        cur_name = nm;
        err_base = err_cnt_o;
    endtask

    // one dac period, pulses equal the dac value
    task automatic measure(input int exp_l, input int exp_r);
        int cnt_l;
        int cnt_r;
        cnt_l = 0;
        cnt_r = 0;
        repeat (256) begin
            @(negedge clk);
            cnt_l += int'(pdm_l_i);
            cnt_r += int'(pdm_r_i);
        end
        if (cnt_l != exp_l) begin
            err_cnt_o++;
            $display("** Error %s: left pulses expected %0d actual %0d", cur_name, exp_l, cnt_l);
        end
        if (cnt_r != exp_r) begin
            err_cnt_o++;
            $display("** Error %s: right pulses expected %0d actual %0d", cur_name, exp_r, cnt_r);
        end
        if (err_cnt_o == err_base) begin
            pass_cnt_o++;
            $display("test %s: passed (L %0d, R %0d)", cur_name, cnt_l, cnt_r);
        end else begin
            fail_cnt_o++;
            $display("test %s: failed with %0d errors", cur_name, err_cnt_o - err_base);
        end
    endtask

endmodule

//--- tb/tb_audio_mixer.sv
// audio mixer testbench with clock, reset, test table, sample memory responder and stimulus loop
`timescale 1ns/1ps

module tb_audio_mixer;
    localparam int NCHAN    = audio_pkg::NCHAN_DEFAULT;
    localparam int NTEST    = 7;
    localparam int SETTLE   = 600;              // cycles before each measurement
    localparam int REQ_WAIT = 200;              // cycles allowed for the first request
    localparam int WATCHDOG = 20000;            // whole run limit in cycles

    logic                               clk;
    logic                               reset_i;
    logic                               enable_i;
    logic [NCHAN-1:0]                   restart_i;
    audio_pkg::addr_t [NCHAN-1:0]       start_i;
    audio_pkg::addr_t [NCHAN-1:0]       length_i;
    audio_pkg::period_t [NCHAN-1:0]     period_i;
    audio_pkg::vol_t [NCHAN-1:0]        vol_l_i;
    audio_pkg::vol_t [NCHAN-1:0]        vol_r_i;
    logic                               mem_req_o;
    audio_pkg::addr_t                   mem_addr_o;
    logic                               mem_ack_i;
    audio_pkg::word_t                   mem_word_i;
    logic [NCHAN-1:0]                   reload_o;
    logic                               pdm_l_o;
    logic                               pdm_r_o;

    // test table with channel 0 in the low field of each packed column
    string                      name_tab [NTEST];
    logic                       en_tab   [NTEST];
    logic [NCHAN-1:0]           rst_tab  [NTEST];
    audio_pkg::sample_t [3:0]   smp_tab  [NTEST];   // constant byte per channel
    audio_pkg::vol_t [3:0]      vl_tab   [NTEST];
    audio_pkg::vol_t [3:0]      vr_tab   [NTEST];
    audio_pkg::addr_t           base_tab [NTEST];   // channel c starts at base + c*256
    audio_pkg::addr_t           len_tab  [NTEST];
    audio_pkg::period_t         per_tab  [NTEST];
    int                         exp_l_tab[NTEST];
    int                         exp_r_tab[NTEST];

    audio_pkg::sample_t [3:0]   smp_now;        // bytes the memory returns now
    int                         misc_fail;      // failures seen outside the checker
    int                         assert_fail;    // failed fetch engine assertions
    int                         pass_cnt;
    int                         fail_cnt;
    int                         err_cnt;

    audio_mixer_top #(.NCHAN(NCHAN), .DAC_W(audio_pkg::DAC_W_DEFAULT)) DUT (.*);

    audio_checker #(.NCHAN(NCHAN)) chk (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .restart_i(restart_i),
        .start_i(start_i), .length_i(length_i), .req_i(mem_req_o), .addr_i(mem_addr_o),
        .reload_i(reload_o), .pdm_l_i(pdm_l_o), .pdm_r_i(pdm_r_o),
        .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt), .err_cnt_o(err_cnt)
    );

    bind sample_fetch audio_mixer_asserts #(.NCHAN(NCHAN)) u_asserts (
        .clk(clk), .reset_i(reset_i), .enable_i(enable_i), .req_i(mem_req_o),
        .addr_i(mem_addr_o), .ack_i(mem_ack_i), .reload_i(reload_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                  // 10 ns period
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("timeout: test sequence did not finish within %0d cycles", WATCHDOG);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic set_row(input int i, input string nm, input logic en, input logic [3:0] rst,
                           input logic [31:0] smp, input logic [27:0] vl, input logic [27:0] vr,
                           input audio_pkg::addr_t base, input audio_pkg::addr_t len,
                           input int el, input int er);
        name_tab[i]  = nm;
        en_tab[i]    = en;
        rst_tab[i]   = rst;
        smp_tab[i]   = smp;
        vl_tab[i]    = vl;
        vr_tab[i]    = vr;
        base_tab[i]  = base;
        len_tab[i]   = len;
        per_tab[i]   = 15'd3;
        exp_l_tab[i] = el;                      // sum of byte*vol, floor /64, clamp, +128
        exp_r_tab[i] = er;
    endtask

    // word with both bytes equal for the channel whose range holds the address
    function automatic audio_pkg::word_t word_for(input audio_pkg::addr_t a);
        for (int c = 0; c < NCHAN; c++) begin
            if ({1'b0, a} >= {1'b0, start_i[c]} &&
                {1'b0, a} <= {1'b0, start_i[c]} + {1'b0, length_i[c]}) begin
                return {smp_now[c], smp_now[c]};
            end
        end
        return '0;
    endfunction

    // sample memory with random ack delay of 0 to 5 cycles
    initial begin
        int dly;
        void'($urandom(1308));                  // fixed seed for the ack delays
        mem_ack_i  = 1'b0;
        mem_word_i = '0;
        forever begin
            @(posedge clk);
            if (mem_req_o && !mem_ack_i && !reset_i) begin
                dly = int'($urandom_range(5, 0));
                while (dly > 0 && mem_req_o) begin  // bounded by the drawn delay
                    @(posedge clk);
                    dly--;
                end
                if (mem_req_o) begin                // request may be cut by disable
                    mem_ack_i  <= 1'b1;
                    mem_word_i <= word_for(mem_addr_o);
                    @(posedge clk);
                    mem_ack_i  <= 1'b0;
                end
            end
        end
    end

    task automatic apply_row(input int i);
        @(posedge clk);
        enable_i  <= en_tab[i];
        restart_i <= rst_tab[i];
        smp_now   <= smp_tab[i];
        for (int c = 0; c < NCHAN; c++) begin
            start_i[c]  <= base_tab[i] + audio_pkg::addr_t'(c * 256);
            length_i[c] <= len_tab[i];
            period_i[c] <= per_tab[i];
            vol_l_i[c]  <= vl_tab[i][c];
            vol_r_i[c]  <= vr_tab[i][c];
        end
        @(posedge clk);
        restart_i <= '0;                        // restart is a single pulse
    endtask

    task automatic wait_for_request(input string nm, input int limit);
        int n;
        n = 0;
        while (!mem_req_o && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (!mem_req_o) begin
            misc_fail++;
            $display("test %s: no memory request within %0d cycles", nm, limit);
        end
    endtask

    initial begin
        misc_fail = 0;
        reset_i   = 1'b1;
        enable_i  = 1'b0;
        restart_i = '0;
        start_i   = '0;
        length_i  = '0;
        period_i  = '0;
        vol_l_i   = '0;
        vol_r_i   = '0;
        smp_now   = '0;
        set_row(0, "mix_level", 1, 4'b0000, {8'h00, 8'h05, 8'hF6, 8'h14},
                {7'd0, 7'd16, 7'd32, 7'd64}, {7'd40, 7'd30, 7'd20, 7'd10},
                16'h1000, 16'd5, 144, 130);
        set_row(1, "mix_negative", 1, 4'b0000, {8'h00, 8'h00, 8'hE2, 8'hE2},
                {7'd0, 7'd0, 7'd7, 7'd7}, {7'd0, 7'd0, 7'd0, 7'd100},
                16'h1000, 16'd5, 121, 81);
        set_row(2, "clamp_high", 1, 4'b0000, {4{8'h7F}},
                {4{7'd127}}, {4{7'd127}}, 16'h1000, 16'd5, 255, 255);
        set_row(3, "clamp_low", 1, 4'b0000, {4{8'h80}},
                {4{7'd127}}, {4{7'd127}}, 16'h1000, 16'd5, 0, 0);
        set_row(4, "restart_ch2", 1, 4'b0100, {8'h00, 8'h05, 8'hF6, 8'h14},
                {7'd0, 7'd16, 7'd32, 7'd64}, {7'd40, 7'd30, 7'd20, 7'd10},
                16'h1000, 16'd5, 144, 130);
        set_row(5, "disabled", 0, 4'b0000, {8'h00, 8'h05, 8'hF6, 8'h14},
                {7'd0, 7'd16, 7'd32, 7'd64}, {7'd40, 7'd30, 7'd20, 7'd10},
                16'h1000, 16'd5, 128, 128);
        set_row(6, "reenable", 1, 4'b0000, {8'h00, 8'h05, 8'hF6, 8'h14},
                {7'd0, 7'd16, 7'd32, 7'd64}, {7'd40, 7'd30, 7'd20, 7'd10},
                16'h2000, 16'd3, 144, 130);
        per_tab[6] = 15'd7;                     // slower playback after re-enable

        repeat (16) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < NTEST; i++) begin
            chk.begin_test(name_tab[i]);
            apply_row(i);
            if (en_tab[i]) begin
                wait_for_request(name_tab[i], REQ_WAIT);
            end
            repeat (SETTLE) @(posedge clk);
            chk.measure(exp_l_tab[i], exp_r_tab[i]);
        end

        assert_fail = DUT.u_fetch.u_asserts.err_cnt;
        $display("tests: %0d passed, %0d failed, %0d check errors, %0d other failures, %0d %s",
                 pass_cnt, fail_cnt, err_cnt, misc_fail, assert_fail, "assertion failures");
        if (fail_cnt == 0 && err_cnt == 0 && misc_fail == 0 && assert_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
rtl/audio_pkg.sv
rtl/sample_load_if.sv
rtl/pdm_dac.sv
rtl/sample_fetch.sv
rtl/channel_buffer.sv
rtl/voice_mixer.sv
rtl/audio_mixer_top.sv
tb/audio_mixer_asserts.sv
tb/audio_checker.sv
tb/tb_audio_mixer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_audio_mixer
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)
